/* hdl/dma_timing_macros.svh */
/*
 * DMA timing and control shared constants
 * Channel count, data width and command/mode register bit positions
 */
`ifndef DMA_TIMING_MACROS_SVH
`define DMA_TIMING_MACROS_SVH

`define DMA_CHANNELS        4
`define DMA_DATA_W          8

// Command register bits
`define CMD_COMPRESSED_BIT  3
`define CMD_EXT_WRITE_BIT   5
`define CMD_DACK_HIGH_BIT   7

// Mode register fields
`define MODE_SEL_LSB        0
`define MODE_TYPE_LSB       2
`define MODE_AUTOINIT_BIT   4
`define MODE_DEC_BIT        5
`define MODE_MODE_LSB       6

`endif

/* hdl/dma_timing_pkg.sv */
/*
 * DMA timing and control types
 * Cycle states, transfer encodings and the bundles passed between blocks
 */
`default_nettype none
`include "dma_timing_macros.svh"

package dma_timing_pkg;

    typedef enum logic [2:0] {SI, S0, S1, S2, S3, SW, S4} dma_state_t;

    // Encodings match the mode register fields
    typedef enum logic [1:0] {VERIFY, WRITE, READ, NONE} xfer_type_t;
    typedef enum logic [1:0] {DEMAND, SINGLE, BLOCK, CASCADE} xfer_mode_t;

    typedef struct packed {
        xfer_mode_t xfer_mode;
        logic       decrement;
        logic       autoinit;
        xfer_type_t xfer_type;
    } chan_mode_t;

    typedef chan_mode_t [`DMA_CHANNELS-1:0] chan_mode_arr_t;

    typedef struct packed {
        logic compressed;
        logic ext_write;
        logic dack_high;
    } cmd_cfg_t;

    typedef logic [`DMA_CHANNELS-1:0] chan_vec_t;

    typedef struct packed {
        logic memr_n;
        logic memw_n;
        logic ior_out_n;
        logic ior_io_n;
        logic iow_out_n;
        logic iow_io_n;
    } bus_strobe_t;

endpackage

`default_nettype wire

/* hdl/dma_mode_regs.sv */
/*
 * DMA command and channel mode registers
 * Decodes command and mode bytes from the internal bus on the falling edge
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_timing_macros.svh"

module dma_mode_regs (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            master_clear_i,
    input  logic [`DMA_DATA_W-1:0]          data_i,
    input  logic                            write_command_i,
    input  logic                            write_mode_i,
    output dma_timing_pkg::cmd_cfg_t        cmd_cfg_o,
    output dma_timing_pkg::chan_mode_arr_t  chan_modes_o,
    output dma_timing_pkg::chan_vec_t       edge_request_o
);
    import dma_timing_pkg::*;

    chan_mode_t new_mode;
    logic [1:0] mode_sel;

    // Decode of the mode byte, cascade carries no transfer type
    always_comb begin
        mode_sel           = data_i[`MODE_SEL_LSB +: 2];
        new_mode.xfer_mode = xfer_mode_t'(data_i[`MODE_MODE_LSB +: 2]);
        new_mode.decrement = data_i[`MODE_DEC_BIT];
        new_mode.autoinit  = data_i[`MODE_AUTOINIT_BIT];
        if (new_mode.xfer_mode == CASCADE) begin
            new_mode.xfer_type = NONE;
        end else begin
            new_mode.xfer_type = xfer_type_t'(data_i[`MODE_TYPE_LSB +: 2]);
        end
    end

    always_ff @(negedge clock, posedge reset) begin
        if (reset) begin
            cmd_cfg_o <= '0;
        end else if (master_clear_i) begin
            cmd_cfg_o <= '0;
        end else if (write_command_i) begin
            cmd_cfg_o.compressed <= data_i[`CMD_COMPRESSED_BIT];
            cmd_cfg_o.ext_write  <= data_i[`CMD_EXT_WRITE_BIT];
            cmd_cfg_o.dack_high  <= data_i[`CMD_DACK_HIGH_BIT];
        end
    end

    always_ff @(negedge clock, posedge reset) begin
        if (reset) begin
            chan_modes_o <= '0;
        end else if (master_clear_i) begin
            chan_modes_o <= '0;
        end else if (write_mode_i) begin
            chan_modes_o[mode_sel] <= new_mode;
        end
    end

    // Single and block mode requests are edge sensitive
    always_comb begin
        for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
            edge_request_o[ch] = (chan_modes_o[ch].xfer_mode == SINGLE) ||
                                 (chan_modes_o[ch].xfer_mode == BLOCK);
        end
    end

endmodule

`default_nettype wire

/* hdl/dma_cycle_fsm.sv */
/*
 * DMA transfer cycle FSM
 * Sequences SI..S4, latches the serviced channel, tracks terminal count,
 * external end-of-process and the hold request
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_timing_macros.svh"

module dma_cycle_fsm (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            master_clear_i,
    input  dma_timing_pkg::cmd_cfg_t        cmd_cfg_i,
    input  dma_timing_pkg::chan_mode_arr_t  chan_modes_i,
    input  dma_timing_pkg::chan_vec_t       request_i,
    input  dma_timing_pkg::chan_vec_t       request_state_i,
    input  logic                            hold_acknowledge_i,
    input  logic                            ready_i,
    input  logic                            update_high_address_i,
    input  logic                            underflow_i,
    input  logic                            end_of_process_n_i,
    output dma_timing_pkg::dma_state_t      state_o,
    output dma_timing_pkg::dma_state_t      next_state_o,
    output dma_timing_pkg::chan_vec_t       active_chan_o,
    output dma_timing_pkg::xfer_type_t      active_type_o,
    output logic                            bus_owned_o,
    output dma_timing_pkg::chan_vec_t       register_select_o,
    output logic                            next_word_o,
    output logic                            decrement_o,
    output logic                            initialize_current_o,
    output logic                            lock_bus_o,
    output logic                            end_of_process_o,
    output logic                            end_of_process_n_o,
    output logic                            hold_request_o
);
    import dma_timing_pkg::*;

    chan_mode_t act_mode;
    logic       cascade;
    logic       req_held;
    logic       verify;
    logic       reload_high;
    logic       terminal_count;
    logic       ext_eop;

    // Mode of the latched channel, active_chan_o is one-hot
    always_comb begin
        act_mode = '0;
        for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
            if (active_chan_o[ch]) begin
                act_mode = chan_modes_i[ch];
            end
        end
    end

    assign cascade  = (act_mode.xfer_mode == CASCADE);
    assign verify   = (act_mode.xfer_type == VERIFY);
    assign req_held = |(active_chan_o & request_state_i);

    always_comb begin
        next_state_o = state_o;
        case (state_o)
            SI: if (request_i != '0) next_state_o = S0;
            S0: if (hold_acknowledge_i) next_state_o = S1;
            S1: next_state_o = cascade ? S4 : S2;
            S2: begin
                if (!cmd_cfg_i.compressed) begin
                    next_state_o = S3;
                end else if (!verify) begin
                    next_state_o = SW;
                end else if (ready_i) begin
                    next_state_o = S4;
                end
            end
            S3: begin
                if (!verify) begin
                    next_state_o = SW;
                end else if (ready_i) begin
                    next_state_o = S4;
                end
            end
            SW: if (ready_i) next_state_o = S4;
            S4: begin
                if (cascade) begin
                    if (!req_held) next_state_o = SI;
                end else if (act_mode.xfer_mode == SINGLE) begin
                    next_state_o = SI;
                end else if ((act_mode.xfer_mode == DEMAND) && !req_held) begin
                    next_state_o = SI;
                end else if (end_of_process_o) begin
                    next_state_o = SI;
                end else begin
                    next_state_o = reload_high ? S1 : S2;
                end
            end
            default: next_state_o = SI;
        endcase
    end

    always_ff @(negedge clock, posedge reset) begin
        if (reset) begin
            state_o       <= SI;
            active_chan_o <= '0;
        end else if (master_clear_i) begin
            state_o       <= SI;
            active_chan_o <= '0;
        end else begin
            state_o <= next_state_o;
            if (state_o == SI) begin
                active_chan_o <= request_i;
            end
        end
    end

    assign active_type_o        = act_mode.xfer_type;
    assign bus_owned_o          = !cascade;
    assign decrement_o          = act_mode.decrement;
    assign next_word_o          = (next_state_o == S4) && !cascade;
    assign register_select_o    = (state_o == SI) ? '0 : active_chan_o;
    assign lock_bus_o           = (state_o != SI) && (state_o != S0);
    assign initialize_current_o = (state_o == S4) && act_mode.autoinit && end_of_process_o;
    assign end_of_process_n_o   = !terminal_count;

    // Hold request and terminal count sample on the rising edge
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            hold_request_o <= 1'b0;
            terminal_count <= 1'b0;
        end else if (master_clear_i) begin
            hold_request_o <= 1'b0;
            terminal_count <= 1'b0;
        end else begin
            if (next_state_o == S0) begin
                hold_request_o <= 1'b1;
            end else if (next_state_o == SI) begin
                hold_request_o <= 1'b0;
            end
            if (state_o == S4) begin
                terminal_count <= 1'b0;
            end else if (next_word_o) begin
                terminal_count <= underflow_i;
            end
        end
    end

    always_ff @(negedge clock, posedge reset) begin
        if (reset) begin
            reload_high      <= 1'b0;
            ext_eop          <= 1'b0;
            end_of_process_o <= 1'b0;
        end else if (master_clear_i) begin
            reload_high      <= 1'b0;
            ext_eop          <= 1'b0;
            end_of_process_o <= 1'b0;
        end else begin
            if (state_o == S2) begin
                reload_high <= 1'b0;
            end else if (next_word_o) begin
                reload_high <= update_high_address_i;
            end
            // External EOP is sampled on the way into S2
            if (state_o == SI) begin
                ext_eop <= 1'b0;
            end else if ((next_state_o == S2) && !end_of_process_n_i) begin
                ext_eop <= 1'b1;
            end
            end_of_process_o <= (next_state_o == S4) && (terminal_count || ext_eop);
        end
    end

endmodule

`default_nettype wire

/* hdl/dma_bus_strobes.sv */
/*
 * DMA bus strobe generator
 * Address enable and strobe, memory and I/O read/write strobes and DACK
 */
`timescale 1ns/10ps
`default_nettype none

module dma_bus_strobes (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        master_clear_i,
    input  dma_timing_pkg::dma_state_t  state_i,
    input  dma_timing_pkg::dma_state_t  next_state_i,
    input  dma_timing_pkg::chan_vec_t   active_chan_i,
    input  dma_timing_pkg::xfer_type_t  active_type_i,
    input  logic                        bus_owned_i,
    input  dma_timing_pkg::cmd_cfg_t    cmd_cfg_i,
    output logic                        address_enable_o,
    output logic                        address_strobe_o,
    output logic                        output_high_address_o,
    output dma_timing_pkg::chan_vec_t   dack_o,
    output dma_timing_pkg::bus_strobe_t strobes_o
);
    import dma_timing_pkg::*;

    chan_vec_t dack_q;
    logic      early_write;
    logic      is_read;
    logic      is_write;

    assign early_write = cmd_cfg_i.ext_write || cmd_cfg_i.compressed;
    assign is_read     = (active_type_i == READ);
    assign is_write    = (active_type_i == WRITE);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            address_enable_o <= 1'b0;
            address_strobe_o <= 1'b0;
        end else if (master_clear_i) begin
            address_enable_o <= 1'b0;
            address_strobe_o <= 1'b0;
        end else begin
            if (!bus_owned_i || (state_i == SI)) begin
                address_enable_o <= 1'b0;
            end else if (state_i == S1) begin
                address_enable_o <= 1'b1;
            end
            address_strobe_o <= bus_owned_i && (state_i == S1);
        end
    end

    // Memory and I/O strobes, active low
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            strobes_o <= '1;
        end else if (master_clear_i) begin
            strobes_o <= '1;
        end else begin
            if ((state_i == S1) && is_write) strobes_o.ior_io_n <= 1'b0;
            else if (state_i == SI)          strobes_o.ior_io_n <= 1'b1;

            if ((state_i == S1) && is_read) strobes_o.iow_io_n <= 1'b0;
            else if (state_i == SI)         strobes_o.iow_io_n <= 1'b1;

            if ((state_i == S2) && is_write) strobes_o.ior_out_n <= 1'b0;
            else if (state_i == S4)          strobes_o.ior_out_n <= 1'b1;

            if ((state_i == S2) && is_read) strobes_o.memr_n <= 1'b0;
            else if (state_i == S4)         strobes_o.memr_n <= 1'b1;

            // Late writes, pulled into S2 for extended or compressed timing
            if (state_i == S4) begin
                strobes_o.iow_out_n <= 1'b1;
                strobes_o.memw_n    <= 1'b1;
            end else if ((state_i == S3) || ((state_i == S2) && early_write)) begin
                if (is_read)  strobes_o.iow_out_n <= 1'b0;
                if (is_write) strobes_o.memw_n    <= 1'b0;
            end
        end
    end

    always_ff @(negedge clock, posedge reset) begin
        if (reset) begin
            output_high_address_o <= 1'b0;
            dack_q                <= '0;
        end else if (master_clear_i) begin
            output_high_address_o <= 1'b0;
            dack_q                <= '0;
        end else begin
            output_high_address_o <= bus_owned_i && (state_i == S1) && (next_state_i == S2);
            if (next_state_i == S2) begin
                dack_q <= active_chan_i;
            end else if (next_state_i == SI) begin
                dack_q <= '0;
            end
        end
    end

    assign dack_o = cmd_cfg_i.dack_high ? dack_q : ~dack_q;

endmodule

`default_nettype wire

/* hdl/dma_tc_status.sv */
/*
 * Terminal count status bits
 * Set per channel on end-of-process, cleared when a status read ends
 */
`timescale 1ns/10ps
`default_nettype none

module dma_tc_status (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      master_clear_i,
    input  logic                      read_status_i,
    input  logic                      end_of_process_i,
    input  dma_timing_pkg::chan_vec_t active_chan_i,
    output dma_timing_pkg::chan_vec_t tc_status_o
);
    logic read_status_q;

    always_ff @(negedge clock, posedge reset) begin
        if (reset) begin
            read_status_q <= 1'b0;
            tc_status_o   <= '0;
        end else begin
            read_status_q <= read_status_i;
            if (master_clear_i || (read_status_q && !read_status_i)) begin
                tc_status_o <= '0;
            end else if (end_of_process_i) begin
                tc_status_o <= tc_status_o | active_chan_i;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dma_timing_top.sv */
/*
 * DMA timing and control top level
 * Mode registers, cycle FSM, bus strobes and terminal count status
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_timing_macros.svh"

module dma_timing_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        master_clear_i,
    input  logic [`DMA_DATA_W-1:0]      data_i,
    input  logic                        write_command_i,
    input  logic                        write_mode_i,
    input  logic                        read_status_i,
    input  dma_timing_pkg::chan_vec_t   request_i,
    input  dma_timing_pkg::chan_vec_t   request_state_i,
    input  logic                        hold_acknowledge_i,
    input  logic                        ready_i,
    input  logic                        update_high_address_i,
    input  logic                        underflow_i,
    input  logic                        end_of_process_n_i,
    output dma_timing_pkg::chan_vec_t   edge_request_o,
    output dma_timing_pkg::chan_vec_t   register_select_o,
    output logic                        next_word_o,
    output logic                        decrement_o,
    output logic                        initialize_current_o,
    output logic                        lock_bus_o,
    output logic                        end_of_process_o,
    output logic                        end_of_process_n_o,
    output logic                        hold_request_o,
    output logic                        address_enable_o,
    output logic                        address_strobe_o,
    output logic                        output_high_address_o,
    output dma_timing_pkg::chan_vec_t   dack_o,
    output dma_timing_pkg::bus_strobe_t strobes_o,
    output dma_timing_pkg::chan_vec_t   tc_status_o
);
    import dma_timing_pkg::*;

    cmd_cfg_t       cmd_cfg;
    chan_mode_arr_t chan_modes;
    dma_state_t     state;
    dma_state_t     next_state;
    chan_vec_t      active_chan;
    xfer_type_t     active_type;
    logic           bus_owned;

    dma_mode_regs mode_regs_i (
        .clock, .reset, .master_clear_i, .data_i, .write_command_i, .write_mode_i,
        .cmd_cfg_o(cmd_cfg), .chan_modes_o(chan_modes), .edge_request_o
    );

    dma_cycle_fsm cycle_fsm_i (
        .clock, .reset, .master_clear_i,
        .cmd_cfg_i(cmd_cfg), .chan_modes_i(chan_modes),
        .request_i, .request_state_i, .hold_acknowledge_i, .ready_i,
        .update_high_address_i, .underflow_i, .end_of_process_n_i,
        .state_o(state), .next_state_o(next_state), .active_chan_o(active_chan),
        .active_type_o(active_type), .bus_owned_o(bus_owned),
        .register_select_o, .next_word_o, .decrement_o, .initialize_current_o,
        .lock_bus_o, .end_of_process_o, .end_of_process_n_o, .hold_request_o
    );

    dma_bus_strobes bus_strobes_i (
        .clock, .reset, .master_clear_i,
        .state_i(state), .next_state_i(next_state), .active_chan_i(active_chan),
        .active_type_i(active_type), .bus_owned_i(bus_owned), .cmd_cfg_i(cmd_cfg),
        .address_enable_o, .address_strobe_o, .output_high_address_o,
        .dack_o, .strobes_o
    );

    dma_tc_status tc_status_i (
        .clock, .reset, .master_clear_i, .read_status_i,
        .end_of_process_i(end_of_process_o), .active_chan_i(active_chan),
        .tc_status_o
    );

endmodule

`default_nettype wire

/* verif/dma_timing_tb.sv */
/*
 * Testbench for the DMA timing and control block
 * Random single, demand, block and cascade cycles checked against a reference model
 */
`timescale 1ns/10ps
`default_nettype none
`include "dma_timing_macros.svh"

module dma_timing_tb;
    import dma_timing_pkg::*;

    localparam int RUNS = 24;

    typedef struct packed {
        chan_vec_t  chan;
        logic [1:0] chan_idx;
        xfer_type_t xfer_type;
        xfer_mode_t xfer_mode;
        logic       autoinit;
        logic       decrement;
        logic       underflow;
        logic       dack_high;
    } run_cfg_t;

    // Everything observed over one run with counts saturating at 3
    typedef struct packed {
        bus_strobe_t strobes_low;
        chan_vec_t   dack_active;
        chan_vec_t   reg_sel;
        logic [1:0]  words;
        logic [1:0]  eops;
        logic [1:0]  int_eops;
        logic [1:0]  inits;
        logic        addr_en;
        logic        addr_stb;
        logic        high_addr;
        logic        locked;
        logic        decrement;
    } run_result_t;

    logic              clock;
    logic              reset;
    logic              master_clear_i;
    logic [7:0]        data_i;
    logic              write_command_i;
    logic              write_mode_i;
    logic              read_status_i;
    chan_vec_t         request_i;
    chan_vec_t         request_state_i;
    logic              hold_acknowledge_i;
    logic              ready_i;
    logic              update_high_address_i;
    logic              underflow_i;
    logic              end_of_process_n_i;
    chan_vec_t         edge_request_o;
    chan_vec_t         register_select_o;
    logic              next_word_o;
    logic              decrement_o;
    logic              initialize_current_o;
    logic              lock_bus_o;
    logic              end_of_process_o;
    logic              end_of_process_n_o;
    logic              hold_request_o;
    logic              address_enable_o;
    logic              address_strobe_o;
    logic              output_high_address_o;
    chan_vec_t         dack_o;
    bus_strobe_t       strobes_o;
    chan_vec_t         tc_status_o;

    logic [31:0]       lfsr_state;
    run_cfg_t          cur;
    run_result_t       seen;
    logic              run_active;
    logic              was_active;
    logic              nw_q;
    logic              init_q;
    logic              eop_n_q;
    logic              eop_q;
    chan_vec_t         status_expect;
    int                runs_checked;

    dma_timing_top dut_i (.*);

    always #2 clock = ~clock;

    // Bus master side grants the bus as soon as it is asked for
    always @(negedge clock) hold_acknowledge_i <= hold_request_o;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [1:0] bump(input logic [1:0] c);
        return (c == 2'd3) ? c : c + 2'd1;
    endfunction

    // Expected outcome of one run from the channel mode and command settings
    function automatic run_result_t expect_run(input run_cfg_t cfg);
        run_result_t r;
        logic        cascade;
        r = '0;
        cascade = (cfg.xfer_mode == CASCADE);
        if (!cascade && cfg.xfer_type == READ) begin
            r.strobes_low.memr_n    = 1'b1;
            r.strobes_low.iow_out_n = 1'b1;
            r.strobes_low.iow_io_n  = 1'b1;
        end
        if (!cascade && cfg.xfer_type == WRITE) begin
            r.strobes_low.memw_n    = 1'b1;
            r.strobes_low.ior_out_n = 1'b1;
            r.strobes_low.ior_io_n  = 1'b1;
        end
        r.dack_active = cascade ? '0 : cfg.chan;
        r.reg_sel     = cfg.chan;
        r.words       = cascade ? 2'd0 : 2'd1;
        r.eops        = (!cascade && cfg.underflow) ? 2'd1 : 2'd0;
        r.int_eops    = r.eops;
        r.inits       = (r.eops != 0 && cfg.autoinit) ? 2'd1 : 2'd0;
        r.addr_en     = !cascade;
        r.addr_stb    = !cascade;
        r.high_addr   = !cascade;
        r.locked      = 1'b1;
        r.decrement   = cfg.decrement;
        return r;
    endfunction

    task automatic report_failure();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s got 'h%0h, expected 'h%0h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic timeout_failure(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        report_failure();
    endtask

    task automatic write_register(input logic cmd, input logic [7:0] value);
        @(negedge clock);
        data_i          <= value;
        write_command_i <= cmd;
        write_mode_i    <= !cmd;
        @(negedge clock);
        write_command_i <= 1'b0;
        write_mode_i    <= 1'b0;
    endtask

    task automatic check_mode_writes();
        logic [7:0] mode_byte;
        chan_vec_t  expected_edge;
        expected_edge = '0;
        for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
            mode_byte = draw_bits(8);
            mode_byte[`MODE_SEL_LSB +: 2] = 2'(ch);
            expected_edge[ch] = (mode_byte[`MODE_MODE_LSB +: 2] == SINGLE) ||
                                (mode_byte[`MODE_MODE_LSB +: 2] == BLOCK);
            write_register(1'b0, mode_byte);
            @(posedge clock);
            check_value("edge_request_o after mode write", edge_request_o, expected_edge);
        end
    endtask

    task automatic run_transfer(input int run);
        run_cfg_t   cfg;
        logic [7:0] rnd;
        logic [7:0] mode_byte;
        logic [7:0] cmd_byte;
        int         hold_len;
        int         n;
        cfg = '0;
        rnd = draw_bits(2);
        cfg.chan_idx = rnd[1:0];
        cfg.chan[cfg.chan_idx] = 1'b1;
        rnd = draw_bits(2);
        cfg.xfer_type = xfer_type_t'(rnd[1:0]);
        rnd = draw_bits(2);
        cfg.xfer_mode = xfer_mode_t'(rnd[1:0]);
        cfg.autoinit  = draw_bits(1);
        // Block mode only stops on terminal count
        cfg.underflow = draw_bits(1) || (cfg.xfer_mode == BLOCK);
        cfg.dack_high = (run >= RUNS / 2);
        hold_len = 2 + draw_bits(3);
        cfg.decrement = draw_bits(1);

        mode_byte = '0;
        mode_byte[`MODE_SEL_LSB +: 2]  = cfg.chan_idx;
        mode_byte[`MODE_TYPE_LSB +: 2] = cfg.xfer_type;
        mode_byte[`MODE_AUTOINIT_BIT]  = cfg.autoinit;
        mode_byte[`MODE_DEC_BIT]       = cfg.decrement;
        mode_byte[`MODE_MODE_LSB +: 2] = cfg.xfer_mode;
        cmd_byte = '0;
        cmd_byte[`CMD_COMPRESSED_BIT] = draw_bits(1);
        cmd_byte[`CMD_EXT_WRITE_BIT]  = draw_bits(1);
        cmd_byte[`CMD_DACK_HIGH_BIT]  = cfg.dack_high;
        write_register(1'b0, mode_byte);
        write_register(1'b1, cmd_byte);

        cur = cfg;
        run_active = 1'b1;
        request_i       <= cfg.chan;
        request_state_i <= (cfg.xfer_mode == CASCADE) ? cfg.chan : '0;
        underflow_i     <= cfg.underflow;
        for (n = 0; n < 10; n++) begin
            @(negedge clock);
            if (hold_request_o) break;
        end
        if (n == 10) timeout_failure("hold_request_o to rise");
        request_i <= '0;

        // Random ready stretches until the bus is given back
        for (n = 0; n < 200; n++) begin
            @(negedge clock);
            rnd = draw_bits(2);
            ready_i <= (rnd[1:0] != 2'b00);
            if (cfg.xfer_mode == CASCADE && n == hold_len) begin
                check_value("hold_request_o while cascade request held", hold_request_o, 1);
                request_state_i <= '0;
            end
            if (!hold_request_o) break;
        end
        if (n == 200) timeout_failure("hold_request_o to fall after the transfer");
        ready_i     <= 1'b1;
        underflow_i <= 1'b0;

        for (n = 0; n < 20; n++) begin
            @(negedge clock);
            if (strobes_o == '1 && !address_enable_o && end_of_process_n_o) break;
        end
        if (n == 20) timeout_failure("strobes and address enable to go idle");
        run_active = 1'b0;
        for (n = 0; n < 10; n++) begin
            @(negedge clock);
            if (runs_checked == run + 1) break;
        end
        if (n == 10) timeout_failure("the monitor to finish comparing a run");

        if (run % 3 == 2) begin
            @(negedge clock);
            read_status_i <= 1'b1;
            @(negedge clock);
            read_status_i <= 1'b0;
            for (n = 0; n < 10; n++) begin
                @(posedge clock);
                if (tc_status_o == '0) break;
            end
            if (n == 10) timeout_failure("tc_status_o to clear after a status read");
            status_expect = '0;
        end
    endtask

    // Samples between edges and compares with the reference when a run ends
    always @(clock) begin : monitor
        run_result_t expected;
        #1;
        if (run_active) begin
            seen.strobes_low = seen.strobes_low | ~strobes_o;
            seen.dack_active = seen.dack_active | (cur.dack_high ? dack_o : ~dack_o);
            seen.reg_sel     = seen.reg_sel | register_select_o;
            seen.addr_en     = seen.addr_en | address_enable_o;
            seen.addr_stb    = seen.addr_stb | address_strobe_o;
            seen.high_addr   = seen.high_addr | output_high_address_o;
            seen.locked      = seen.locked | lock_bus_o;
            seen.decrement   = seen.decrement | decrement_o;
            if (next_word_o && !nw_q) seen.words = bump(seen.words);
            if (initialize_current_o && !init_q) seen.inits = bump(seen.inits);
            if (!end_of_process_n_o && eop_n_q) seen.eops = bump(seen.eops);
            if (end_of_process_o && !eop_q) seen.int_eops = bump(seen.int_eops);
        end else if (was_active) begin
            expected = expect_run(cur);
            check_value("strobes driven low", seen.strobes_low, expected.strobes_low);
            check_value("active DACK bits", seen.dack_active, expected.dack_active);
            check_value("register_select_o seen", seen.reg_sel, expected.reg_sel);
            check_value("next_word pulses", seen.words, expected.words);
            check_value("end_of_process_n_o pulses", seen.eops, expected.eops);
            check_value("end_of_process_o pulses", seen.int_eops, expected.int_eops);
            check_value("initialize_current_o pulses", seen.inits, expected.inits);
            check_value("address_enable_o seen", seen.addr_en, expected.addr_en);
            check_value("address_strobe_o seen", seen.addr_stb, expected.addr_stb);
            check_value("output_high_address_o seen", seen.high_addr, expected.high_addr);
            check_value("lock_bus_o seen", seen.locked, expected.locked);
            check_value("decrement_o seen", seen.decrement, expected.decrement);
            if (expected.eops != 0) begin
                status_expect = status_expect | cur.chan;
            end
            check_value("tc_status_o", tc_status_o, status_expect);
            seen = '0;
            runs_checked = runs_checked + 1;
        end
        nw_q       = next_word_o;
        init_q     = initialize_current_o;
        eop_n_q    = end_of_process_n_o;
        eop_q      = end_of_process_o;
        was_active = run_active;
    end

    initial begin
        clock                 = 1'b0;
        reset                 = 1'b1;
        master_clear_i        = 1'b0;
        data_i                = '0;
        write_command_i       = 1'b0;
        write_mode_i          = 1'b0;
        read_status_i         = 1'b0;
        request_i             = '0;
        request_state_i       = '0;
        hold_acknowledge_i    = 1'b0;
        ready_i               = 1'b1;
        update_high_address_i = 1'b0;
        underflow_i           = 1'b0;
        end_of_process_n_i    = 1'b1;
        lfsr_state            = 32'h76b2;
        cur                   = '0;
        seen                  = '0;
        run_active            = 1'b0;
        was_active            = 1'b0;
        nw_q                  = 1'b0;
        init_q                = 1'b0;
        eop_n_q               = 1'b1;
        eop_q                 = 1'b0;
        status_expect         = '0;
        runs_checked          = 0;

        repeat (4) @(posedge clock);
        @(negedge clock);
        reset <= 1'b0;
        @(posedge clock);
        #1;
        check_value("strobes after reset", strobes_o, 6'h3f);
        check_value("end_of_process_n_o after reset", end_of_process_n_o, 1);
        check_value("dack_o after reset", dack_o, 4'hf);
        check_value("hold_request_o after reset", hold_request_o, 0);
        check_value("address_enable_o after reset", address_enable_o, 0);
        check_value("tc_status_o after reset", tc_status_o, 0);

        check_mode_writes();
        for (int run = 0; run < RUNS; run++) begin
            run_transfer(run);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dma_timing_top.f */
+incdir+hdl
hdl/dma_timing_pkg.sv
hdl/dma_mode_regs.sv
hdl/dma_cycle_fsm.sv
hdl/dma_bus_strobes.sv
hdl/dma_tc_status.sv
hdl/dma_timing_top.sv
verif/dma_timing_tb.sv

/* Bender.yml */
package:
  name: dma_timing

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dma_timing_pkg.sv
      - hdl/dma_mode_regs.sv
      - hdl/dma_cycle_fsm.sv
      - hdl/dma_bus_strobes.sv
      - hdl/dma_tc_status.sv
      - hdl/dma_timing_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/dma_timing_tb.sv
